// ==== source/clint_pkg.sv ====
package clint_pkg;

  // Wishbone data path and timer widths
  localparam int BUS_W  = 32;
  localparam int TIME_W = 64;

  // Clocks per mtime step, small so counting is visible in simulation
  localparam int TICK_CYCLES = 4;
  localparam int TICK_W      = $clog2(TICK_CYCLES);

  typedef logic [BUS_W-1:0]  bus_data_t;
  typedef logic [TIME_W-1:0] time_t;
  typedef logic [TICK_W-1:0] tick_cnt_t;

  // Last prescaler count before mtime steps
  localparam tick_cnt_t TICK_LAST = tick_cnt_t'(TICK_CYCLES - 1);

  // Word address: bit 2 picks the high half, bits 1:0 the register
  typedef logic [2:0] reg_addr_t;

  localparam logic [1:0] ADDR_MSIP     = 2'd0;
  localparam logic [1:0] ADDR_MTIME    = 2'd2;
  localparam logic [1:0] ADDR_MTIMECMP = 2'd3;

  // One-hot register select
  typedef logic [2:0] reg_sel_t;

  localparam int SEL_MSIP     = 0;
  localparam int SEL_MTIME    = 1;
  localparam int SEL_MTIMECMP = 2;

  // Acknowledge sequencer
  typedef enum logic [1:0] {
    ACK_IDLE,
    ACK_PEND,
    ACK_SEND
  } ack_state_t;

endpackage

// ==== source/clint_bus_decode.sv ====
module clint_bus_decode (
  input  logic                 CLK_I,
  input  logic                 RST_I,
  input  logic                 CYC_I,
  input  logic                 STB_I,
  input  logic                 WE_I,
  input  clint_pkg::reg_addr_t ADR_I,
  output clint_pkg::reg_sel_t  wr_sel,
  output clint_pkg::reg_sel_t  rd_sel,
  output logic                 hi_half,
  output logic                 ACK_O
);

  logic                  req;
  clint_pkg::reg_sel_t   code_sel;
  clint_pkg::ack_state_t state;
  clint_pkg::ack_state_t state_nxt;

  assign req     = CYC_I & STB_I;
  assign hi_half = ADR_I[2];

  // Register code to one-hot, code 1 selects nothing
  always_comb begin
    code_sel = '0;
    case (ADR_I[1:0])
      clint_pkg::ADDR_MSIP: begin
        code_sel[clint_pkg::SEL_MSIP] = 1'b1;
      end
      clint_pkg::ADDR_MTIME: begin
        code_sel[clint_pkg::SEL_MTIME] = 1'b1;
      end
      clint_pkg::ADDR_MTIMECMP: begin
        code_sel[clint_pkg::SEL_MTIMECMP] = 1'b1;
      end
      default: begin
        code_sel = '0;
      end
    endcase
  end

  // Strobes stay up for every cycle the write is held
  assign wr_sel = (req && WE_I) ? code_sel : '0;

  // Follows the address only, so DAT_O holds through the ACK cycle
  assign rd_sel = code_sel;

  // Request at edge n, ACK_O high from edge n+1 to n+2
  always_comb begin
    state_nxt = state;
    case (state)
      clint_pkg::ACK_IDLE: begin
        if (req) begin
          state_nxt = clint_pkg::ACK_PEND;
        end
      end
      clint_pkg::ACK_PEND: begin
        state_nxt = clint_pkg::ACK_SEND;
      end
      clint_pkg::ACK_SEND: begin
        // Held request is taken again
        if (req) begin
          state_nxt = clint_pkg::ACK_PEND;
        end else begin
          state_nxt = clint_pkg::ACK_IDLE;
        end
      end
      default: begin
        state_nxt = clint_pkg::ACK_IDLE;
      end
    endcase
  end

  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      state <= clint_pkg::ACK_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign ACK_O = (state == clint_pkg::ACK_SEND);

endmodule

// ==== source/clint_timer.sv ====
module clint_timer (
  input  logic                 CLK_I,
  input  logic                 RST_I,
  input  logic                 wr_mtime,
  input  logic                 hi_half,
  input  clint_pkg::bus_data_t DAT_I,
  output clint_pkg::time_t     mtime
);

  clint_pkg::tick_cnt_t prescale;
  logic                 tick;

  // One tick every TICK_CYCLES clocks
  assign tick = (prescale == clint_pkg::TICK_LAST);

  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      prescale <= '0;
    end else if (tick) begin
      prescale <= '0;
    end else begin
      prescale <= prescale + 1'b1;
    end
  end

  // Bus write wins over the increment
  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      mtime <= '0;
    end else if (wr_mtime) begin
      if (hi_half) begin
        mtime[clint_pkg::TIME_W-1:clint_pkg::BUS_W] <= DAT_I;
      end else begin
        mtime[clint_pkg::BUS_W-1:0] <= DAT_I;
      end
    end else if (tick) begin
      mtime <= mtime + 1'b1;
    end
  end

endmodule

// ==== source/clint_regs.sv ====
module clint_regs (
  input  logic                 CLK_I,
  input  logic                 RST_I,
  input  clint_pkg::reg_sel_t  wr_sel,
  input  clint_pkg::reg_sel_t  rd_sel,
  input  logic                 hi_half,
  input  clint_pkg::bus_data_t DAT_I,
  input  clint_pkg::time_t     mtime,
  output clint_pkg::bus_data_t DAT_O,
  output logic                 msip_irq,
  output logic                 mtip_irq
);

  clint_pkg::bus_data_t msip;
  clint_pkg::time_t     mtimecmp;

  // Upper or lower word of a 64-bit register
  function automatic clint_pkg::bus_data_t pick_half(clint_pkg::time_t value, logic hi);
    clint_pkg::bus_data_t word;
    if (hi) begin
      word = value[clint_pkg::TIME_W-1:clint_pkg::BUS_W];
    end else begin
      word = value[clint_pkg::BUS_W-1:0];
    end
    return word;
  endfunction

  // msip is a single word, address bit 2 is ignored
  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      msip <= '0;
    end else if (wr_sel[clint_pkg::SEL_MSIP]) begin
      msip <= DAT_I;
    end
  end

  // All ones keeps the timer interrupt off after reset
  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      mtimecmp <= '1;
    end else if (wr_sel[clint_pkg::SEL_MTIMECMP]) begin
      if (hi_half) begin
        mtimecmp[clint_pkg::TIME_W-1:clint_pkg::BUS_W] <= DAT_I;
      end else begin
        mtimecmp[clint_pkg::BUS_W-1:0] <= DAT_I;
      end
    end
  end

  // Read mux, zero when nothing is selected
  always_comb begin
    DAT_O = '0;
    if (rd_sel[clint_pkg::SEL_MSIP]) begin
      DAT_O = msip;
    end else if (rd_sel[clint_pkg::SEL_MTIME]) begin
      DAT_O = pick_half(mtime, hi_half);
    end else if (rd_sel[clint_pkg::SEL_MTIMECMP]) begin
      DAT_O = pick_half(mtimecmp, hi_half);
    end
  end

  assign msip_irq = msip[0];

  // Unsigned compare over the full 64 bits
  assign mtip_irq = (mtime >= mtimecmp);

endmodule

// ==== source/clint_top.sv ====
module clint_top (
  input  logic                 CLK_I,
  input  logic                 RST_I,
  input  logic                 CYC_I,
  input  logic                 STB_I,
  input  logic                 WE_I,
  input  clint_pkg::reg_addr_t ADR_I,
  input  clint_pkg::bus_data_t DAT_I,
  output clint_pkg::bus_data_t DAT_O,
  output logic                 ACK_O,
  output logic                 msip_irq,
  output logic                 mtip_irq,
  output clint_pkg::time_t     mtime
);

  clint_pkg::reg_sel_t wr_sel;
  clint_pkg::reg_sel_t rd_sel;
  logic                hi_half;

  clint_bus_decode u_decode (
    .CLK_I   (CLK_I),
    .RST_I   (RST_I),
    .CYC_I   (CYC_I),
    .STB_I   (STB_I),
    .WE_I    (WE_I),
    .ADR_I   (ADR_I),
    .wr_sel  (wr_sel),
    .rd_sel  (rd_sel),
    .hi_half (hi_half),
    .ACK_O   (ACK_O)
  );

  clint_timer u_timer (
    .CLK_I    (CLK_I),
    .RST_I    (RST_I),
    .wr_mtime (wr_sel[clint_pkg::SEL_MTIME]),
    .hi_half  (hi_half),
    .DAT_I    (DAT_I),
    .mtime    (mtime)
  );

  clint_regs u_regs (
    .CLK_I    (CLK_I),
    .RST_I    (RST_I),
    .wr_sel   (wr_sel),
    .rd_sel   (rd_sel),
    .hi_half  (hi_half),
    .DAT_I    (DAT_I),
    .mtime    (mtime),
    .DAT_O    (DAT_O),
    .msip_irq (msip_irq),
    .mtip_irq (mtip_irq)
  );

endmodule

// ==== testbench/clint_clk_gen.sv ====
module clint_clk_gen (
  output logic CLK_I,
  output logic RST_I
);

  localparam int HALF_PERIOD  = 20;
  localparam int RESET_CYCLES = 4;

  initial begin
    CLK_I = 1'b0;
    forever #HALF_PERIOD CLK_I = ~CLK_I;
  end

  // Reset released on the edge that ends the fourth cycle
  initial begin
    RST_I = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK_I);
    RST_I <= 1'b0;
  end

endmodule

// ==== testbench/clint_sva.sv ====
module clint_sva (
  input logic                 CLK_I,
  input logic                 RST_I,
  input logic                 CYC_I,
  input logic                 STB_I,
  input logic                 ACK_O,
  input clint_pkg::reg_sel_t  wr_sel,
  input logic                 hi_half,
  input clint_pkg::bus_data_t DAT_I,
  input logic                 msip_irq,
  input logic                 mtip_irq,
  input clint_pkg::time_t     mtime
);

  logic req;

  assign req = CYC_I & STB_I;

  // New request gets its ACK two edges later
  ack_latency: assert property (@(posedge CLK_I) disable iff (RST_I)
    $past(req, 2) && !$past(req, 3) |-> ACK_O)
    else $error("ACK_O missing two cycles after a new request");

  ack_has_request: assert property (@(posedge CLK_I) disable iff (RST_I)
    ACK_O |-> $past(req, 2))
    else $error("ACK_O without a request two cycles before");

  ack_single: assert property (@(posedge CLK_I) disable iff (RST_I)
    ACK_O |=> !ACK_O)
    else $error("ACK_O longer than one cycle");

  // Written half of mtime lands whole, even on a tick
  mtime_load: assert property (@(posedge CLK_I) disable iff (RST_I)
    wr_sel[clint_pkg::SEL_MTIME] |=>
      (($past(hi_half) ? mtime[clint_pkg::TIME_W-1:clint_pkg::BUS_W]
                       : mtime[clint_pkg::BUS_W-1:0]) == $past(DAT_I)))
    else $error("mtime half does not hold the written word");

  // Bit 0 of a msip write shows on msip_irq
  msip_write: assert property (@(posedge CLK_I) disable iff (RST_I)
    wr_sel[clint_pkg::SEL_MSIP] |=> (msip_irq == $past(DAT_I[0])))
    else $error("msip_irq does not follow the written msip bit 0");

  // mtime only counts up, so mtip_irq holds until a register write
  mtip_hold: assert property (@(posedge CLK_I) disable iff (RST_I)
    mtip_irq && (wr_sel == '0) |=> mtip_irq)
    else $error("mtip_irq dropped without a register write");

endmodule

// Sees the decoder and register file signals through the top level
bind clint_top clint_sva u_sva (
  .CLK_I    (CLK_I),
  .RST_I    (RST_I),
  .CYC_I    (CYC_I),
  .STB_I    (STB_I),
  .ACK_O    (ACK_O),
  .wr_sel   (wr_sel),
  .hi_half  (hi_half),
  .DAT_I    (DAT_I),
  .msip_irq (msip_irq),
  .mtip_irq (mtip_irq),
  .mtime    (mtime)
);

// ==== testbench/clint_tb.sv ====
module clint_tb;

  localparam int          CLK_PERIOD        = 40;
  localparam int          CYCLES_PER_VECTOR = 20;
  localparam int          MAX_VECTORS       = 64;
  localparam int          ACK_LIMIT         = 8;
  localparam int          MAX_IDLE          = 3;
  localparam int unsigned SEED              = 32'h6730;

  localparam logic [3:0] OP_WRITE = 4'h0;
  localparam logic [3:0] OP_READ  = 4'h1;
  localparam logic [3:0] OP_IRQ   = 4'h2;
  localparam logic [3:0] OP_WAIT  = 4'h3;
  localparam logic [3:0] OP_TIMER = 4'h4;
  localparam logic [3:0] OP_END   = 4'hf;

  logic                 CLK_I;
  logic                 RST_I;
  logic                 CYC_I;
  logic                 STB_I;
  logic                 WE_I;
  clint_pkg::reg_addr_t ADR_I;
  clint_pkg::bus_data_t DAT_I;
  clint_pkg::bus_data_t DAT_O;
  logic                 ACK_O;
  logic                 msip_irq;
  logic                 mtip_irq;
  clint_pkg::time_t     mtime;

  // Four words per vector: op, address, data, expected
  logic [31:0] vec_mem [0:4*MAX_VECTORS-1];

  int     num_vectors      = 0;
  logic   vectors_loaded   = 1'b0;
  int     error_count      = 0;
  int     pass_count       = 0;
  int     fail_count       = 0;
  longint cycle_count      = 0;
  longint last_ack_cycle   = 0;
  longint mtime_load_cycle = 0;
  longint watchdog_time;

  clint_clk_gen clk_gen (
    .CLK_I (CLK_I),
    .RST_I (RST_I)
  );

  clint_top UUT (
    .CLK_I    (CLK_I),
    .RST_I    (RST_I),
    .CYC_I    (CYC_I),
    .STB_I    (STB_I),
    .WE_I     (WE_I),
    .ADR_I    (ADR_I),
    .DAT_I    (DAT_I),
    .DAT_O    (DAT_O),
    .ACK_O    (ACK_O),
    .msip_irq (msip_irq),
    .mtip_irq (mtip_irq),
    .mtime    (mtime)
  );

  always @(posedge CLK_I) begin
    cycle_count <= cycle_count + 1;
  end

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("FAILED %s: got %h, expected %h", name, actual, expected);
      error_count++;
    end
  endtask

  // Counter may only have moved by the ticks since the load, plus one
  task automatic verify_mtime_range(input string name, input logic [63:0] value,
                                    input logic [63:0] lower, input longint elapsed);
    logic [63:0] upper;
    upper = lower + 64'(elapsed / clint_pkg::TICK_CYCLES) + 64'd1;
    if (value < lower || value > upper) begin
      $display("%s lies outside %h to %h", name, lower, upper);
      check_value(name, value, (value < lower) ? lower : upper);
    end
  endtask

  task automatic load_vectors();
    int idx;
    for (idx = 0; idx < 4 * MAX_VECTORS; idx++) begin
      vec_mem[idx] = 32'hf;
    end
    $readmemh("testbench/clint_vectors.txt", vec_mem);
    idx = 0;
    while (idx < MAX_VECTORS && vec_mem[4*idx][3:0] != OP_END) begin
      idx++;
    end
    num_vectors = idx;
  endtask

  // Called on a falling edge, returns on the falling edge after ACK_O is low again
  task automatic bus_access(input logic is_write, input clint_pkg::reg_addr_t adr,
                            input clint_pkg::bus_data_t wdata,
                            output clint_pkg::bus_data_t rdata);
    int   latency;
    logic got_ack;
    latency = 0;
    got_ack = 1'b0;
    rdata   = '0;
    CYC_I   = 1'b1;
    STB_I   = 1'b1;
    WE_I    = is_write;
    ADR_I   = adr;
    DAT_I   = wdata;
    while (!got_ack && latency < ACK_LIMIT) begin
      @(negedge CLK_I);
      latency++;
      got_ack = ACK_O;
    end
    CYC_I = 1'b0;
    STB_I = 1'b0;
    WE_I  = 1'b0;
    if (!got_ack) begin
      $display("No acknowledge arrived within %0d cycles for address %0h", ACK_LIMIT, adr);
      error_count++;
    end else begin
      rdata          = DAT_O;
      last_ack_cycle = cycle_count;
      check_value("ACK_O latency", 64'(latency), 64'd2);
      @(negedge CLK_I);
      check_value("ACK_O width", 64'(ACK_O), 64'd0);
    end
  endtask

  task automatic run_vector(input int idx);
    logic [3:0]           op;
    clint_pkg::reg_addr_t adr;
    clint_pkg::bus_data_t data;
    clint_pkg::bus_data_t expected;
    clint_pkg::bus_data_t rdata;
    int                   errors_before;
    int unsigned          idle;
    string                label;
    op            = vec_mem[4*idx][3:0];
    adr           = vec_mem[4*idx+1][2:0];
    data          = vec_mem[4*idx+2];
    expected      = vec_mem[4*idx+3];
    errors_before = error_count;
    case (op)
      OP_WRITE: begin
        label = "write";
        bus_access(1'b1, adr, data, rdata);
        if (adr[1:0] == clint_pkg::ADDR_MTIME) begin
          mtime_load_cycle = last_ack_cycle;
        end
      end
      OP_READ: begin
        label = "read";
        bus_access(1'b0, adr, '0, rdata);
        check_value($sformatf("DAT_O at %0h", adr), 64'(rdata), 64'(expected));
      end
      OP_IRQ: begin
        label = "irq";
        check_value("{mtip_irq, msip_irq}", 64'({mtip_irq, msip_irq}), 64'(expected[1:0]));
      end
      OP_WAIT: begin
        label = "wait";
        repeat (data) @(negedge CLK_I);
      end
      OP_TIMER: begin
        label = "timer";
        bus_access(1'b0, adr, '0, rdata);
        verify_mtime_range("DAT_O mtime", 64'(rdata), 64'(expected),
                           last_ack_cycle - mtime_load_cycle);
        // Full counter port, high half cleared by an earlier write
        verify_mtime_range("mtime", mtime, 64'(expected), cycle_count - mtime_load_cycle);
      end
      default: begin
        label = "unknown";
        $display("Vector %0d has an unknown operation code %0h", idx, op);
        error_count++;
      end
    endcase
    if (error_count == errors_before) begin
      pass_count++;
      $display("test %0d %s adr %0h: ok", idx, label, adr);
    end else begin
      fail_count++;
      $display("test %0d %s adr %0h: error", idx, label, adr);
    end
    idle = $urandom_range(0, MAX_IDLE);
    repeat (idle) @(negedge CLK_I);
  endtask

  initial begin
    CYC_I = 1'b0;
    STB_I = 1'b0;
    WE_I  = 1'b0;
    ADR_I = '0;
    DAT_I = '0;
    void'($urandom(SEED));
    load_vectors();
    vectors_loaded = 1'b1;
    if (num_vectors == 0) begin
      $display("No vectors found in the data file");
      error_count++;
    end
    @(negedge RST_I);
    @(negedge CLK_I);
    for (int i = 0; i < num_vectors; i++) begin
      run_vector(i);
    end
    $display("%0d tests, %0d ok, %0d with errors, %0d errors in total",
             num_vectors, pass_count, fail_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog sized from the vector count
  initial begin
    wait (vectors_loaded);
    watchdog_time = longint'(num_vectors) * CYCLES_PER_VECTOR * CLK_PERIOD;
    #(watchdog_time);
    $display("Watchdog expired before all vectors finished");
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== testbench/clint_vectors.txt ====
// op addr data expected (hex), one bus operation per line
// op 0 write, 1 read, 2 irq {mtip,msip}, 3 wait data cycles, 4 mtime range read, f end
2 0 00000000 00000000
1 0 00000000 00000000
1 3 00000000 ffffffff
1 7 00000000 ffffffff
0 0 a5a5a5a4 00000000
1 0 00000000 a5a5a5a4
2 0 00000000 00000000
0 3 12345678 00000000
1 3 00000000 12345678
0 7 9abcdef0 00000000
1 7 00000000 9abcdef0
0 1 deadbeef 00000000
1 1 00000000 00000000
1 5 00000000 00000000
0 0 00000001 00000000
2 0 00000000 00000001
0 0 fffffffe 00000000
2 0 00000000 00000000
1 0 00000000 fffffffe
0 6 00000000 00000000
0 2 00000100 00000000
3 0 00000028 00000000
4 2 00000000 00000100
1 6 00000000 00000000
0 2 00000000 00000000
0 7 00000000 00000000
0 3 00000030 00000000
2 0 00000000 00000000
3 0 000000d0 00000000
2 0 00000000 00000002
0 7 00000001 00000000
2 0 00000000 00000000
1 7 00000000 00000001
f 0 00000000 00000000

// ==== all.f ====
source/clint_pkg.sv
source/clint_bus_decode.sv
source/clint_timer.sv
source/clint_regs.sv
source/clint_top.sv
testbench/clint_clk_gen.sv
testbench/clint_sva.sv
testbench/clint_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module clint_tb -f all.f -o clint_sim

./obj_dir/clint_sim | tee sim.log

if grep -q "TEST PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
